//--- common/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // RV32 fixes the data and address width
    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [STRB_W-1:0] strb_t;

    // Access kind decoded from opcode and funct3
    typedef enum logic [3:0] {
        MK_NONE,
        MK_LB,
        MK_LH,
        MK_LW,
        MK_LBU,
        MK_LHU,
        MK_SB,
        MK_SH,
        MK_SW
    } mem_kind_e;

    // Request from execute
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     result;
        word_t     addr;
        word_t     rs2;
        reg_addr_t rd;
    } exe_req_t;

    // Request to write-back
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     result;
        word_t     load_data;
        reg_addr_t rd;
    } wb_req_t;

    // AXI4-Lite channel payloads, responses are always OKAY
    typedef struct packed {
        word_t addr;
    } axil_aw_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        word_t addr;
    } axil_ar_t;

    typedef struct packed {
        word_t data;
    } axil_r_t;

endpackage

`default_nettype wire

//--- mem_stage/mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       exe_valid_i,
    input  wire mem_stage_pkg::exe_req_t exe_req_i,
    output logic                      exe_ready_o,
    output logic                      wb_valid_o,
    output mem_stage_pkg::wb_req_t    wb_req_o,
    input  wire                       wb_ready_i,
    output logic                      aw_valid_o,
    output mem_stage_pkg::axil_aw_t   aw_o,
    input  wire                       aw_ready_i,
    output logic                      w_valid_o,
    output mem_stage_pkg::axil_w_t    w_o,
    input  wire                       w_ready_i,
    input  wire                       b_valid_i,
    output logic                      b_ready_o,
    output logic                      ar_valid_o,
    output mem_stage_pkg::axil_ar_t   ar_o,
    input  wire                       ar_ready_i,
    input  wire                       r_valid_i,
    input  wire mem_stage_pkg::axil_r_t r_i,
    output logic                      r_ready_o,
    output mem_stage_pkg::mem_kind_e  kind_o,
    output logic [1:0]                addr_lo_o,
    output mem_stage_pkg::word_t      store_data_o,
    input  wire mem_stage_pkg::axil_w_t w_fmt_i,
    input  wire mem_stage_pkg::word_t load_value_i
);
    import mem_stage_pkg::*;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_RESP,
        DONE
    } state_e;

    state_e    state_q;
    mem_kind_e kind_q;
    mem_kind_e kind_dec;
    exe_req_t  req_q;
    word_t     load_data_q;
    logic      aw_done_q;
    logic      w_done_q;
    logic      is_load;
    logic      is_store;
    logic      accept;
    logic      ar_hs;
    logic      r_hs;
    logic      b_hs;
    logic      wr_issued;

    // Decode from the incoming instruction so the kind is latched on accept
    always_comb begin
        kind_dec = MK_NONE;
        if (exe_req_i.inst[6:0] == OPC_LOAD) begin
            case (exe_req_i.inst[14:12])
                3'b000:  kind_dec = MK_LB;
                3'b001:  kind_dec = MK_LH;
                3'b010:  kind_dec = MK_LW;
                3'b100:  kind_dec = MK_LBU;
                3'b101:  kind_dec = MK_LHU;
                default: kind_dec = MK_NONE;
            endcase
        end else if (exe_req_i.inst[6:0] == OPC_STORE) begin
            case (exe_req_i.inst[14:12])
                3'b000:  kind_dec = MK_SB;
                3'b001:  kind_dec = MK_SH;
                3'b010:  kind_dec = MK_SW;
                default: kind_dec = MK_NONE;
            endcase
        end
    end

    assign is_load  = kind_q inside {MK_LB, MK_LH, MK_LW, MK_LBU, MK_LHU};
    assign is_store = kind_q inside {MK_SB, MK_SH, MK_SW};

    assign exe_ready_o = (state_q == IDLE);
    assign accept      = exe_valid_i && exe_ready_o;

    // aw and w drop on their own once each is taken
    assign aw_valid_o = (state_q == ISSUE) && is_store && !aw_done_q;
    assign w_valid_o  = (state_q == ISSUE) && is_store && !w_done_q;
    assign ar_valid_o = (state_q == ISSUE) && is_load;
    assign b_ready_o  = (state_q == WAIT_RESP) && is_store;
    assign r_ready_o  = (state_q == WAIT_RESP) && is_load;

    assign ar_hs = ar_valid_o && ar_ready_i;
    assign r_hs  = r_valid_i && r_ready_o;
    assign b_hs  = b_valid_i && b_ready_o;
    // Both store beats accepted, counting this cycle
    assign wr_issued = (aw_done_q || (aw_valid_o && aw_ready_i)) &&
                       (w_done_q || (w_valid_o && w_ready_i));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= IDLE;
            kind_q    <= MK_NONE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        kind_q    <= kind_dec;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= (kind_dec == MK_NONE) ? DONE : ISSUE;
                    end
                end
                ISSUE: begin
                    if (aw_valid_o && aw_ready_i) begin
                        aw_done_q <= 1'b1;
                    end
                    if (w_valid_o && w_ready_i) begin
                        w_done_q <= 1'b1;
                    end
                    if (ar_hs || (is_store && wr_issued)) begin
                        state_q <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (r_hs || b_hs) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (wb_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request fields and load result
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q       <= exe_req_i;
            load_data_q <= '0;
        end else if (r_hs) begin
            load_data_q <= load_value_i;
        end
    end

    assign aw_o = '{addr: req_q.addr};
    assign ar_o = '{addr: req_q.addr};
    assign w_o  = w_fmt_i;

    assign kind_o       = kind_q;
    assign addr_lo_o    = req_q.addr[1:0];
    assign store_data_o = req_q.rs2;

    assign wb_valid_o = (state_q == DONE);

    always_comb begin
        wb_req_o.pc        = req_q.pc;
        wb_req_o.inst      = req_q.inst;
        wb_req_o.result    = req_q.result;
        wb_req_o.load_data = load_data_q;
        wb_req_o.rd        = req_q.rd;
    end

endmodule

`default_nettype wire

//--- mem_stage/load_align.sv
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  wire mem_stage_pkg::mem_kind_e kind_i,
    input  wire [1:0]                     addr_lo_i,
    input  wire mem_stage_pkg::word_t     rdata_i,
    output mem_stage_pkg::word_t          value_o
);
    import mem_stage_pkg::*;

    word_t shifted;

    // Bring the addressed byte or halfword down to bit 0
    assign shifted = rdata_i >> {addr_lo_i, 3'b000};

    always_comb begin
        case (kind_i)
            MK_LB: begin
                value_o = {{(XLEN - 8){shifted[7]}}, shifted[7:0]};
            end
            MK_LBU: begin
                value_o = {{(XLEN - 8){1'b0}}, shifted[7:0]};
            end
            MK_LH: begin
                value_o = {{(XLEN - 16){shifted[15]}}, shifted[15:0]};
            end
            MK_LHU: begin
                value_o = {{(XLEN - 16){1'b0}}, shifted[15:0]};
            end
            MK_LW: begin
                value_o = rdata_i;
            end
            // Stores and non-memory instructions load nothing
            default: begin
                value_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- mem_stage/store_format.sv
`timescale 1ns/100ps
`default_nettype none

module store_format (
    input  wire mem_stage_pkg::mem_kind_e kind_i,
    input  wire [1:0]                     addr_lo_i,
    input  wire mem_stage_pkg::word_t     rs2_i,
    output mem_stage_pkg::axil_w_t        w_o
);
    import mem_stage_pkg::*;

    always_comb begin
        case (kind_i)
            MK_SB: begin
                // Byte copied to every lane, strobe picks one
                w_o.data = {4{rs2_i[7:0]}};
                w_o.strb = strb_t'(4'b0001) << addr_lo_i;
            end
            MK_SH: begin
                w_o.data = {2{rs2_i[15:0]}};
                w_o.strb = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            MK_SW: begin
                w_o.data = rs2_i;
                w_o.strb = '1;
            end
            default: begin
                w_o.data = rs2_i;
                w_o.strb = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/axil_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axil_sram #(
    parameter int MEM_ADDR_BITS = 8,
    parameter int RESP_DELAY    = 2
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          aw_valid_i,
    input  wire mem_stage_pkg::axil_aw_t aw_i,
    output logic                         aw_ready_o,
    input  wire                          w_valid_i,
    input  wire mem_stage_pkg::axil_w_t  w_i,
    output logic                         w_ready_o,
    output logic                         b_valid_o,
    input  wire                          b_ready_i,
    input  wire                          ar_valid_i,
    input  wire mem_stage_pkg::axil_ar_t ar_i,
    output logic                         ar_ready_o,
    output logic                         r_valid_o,
    output mem_stage_pkg::axil_r_t       r_o,
    input  wire                          r_ready_i
);
    import mem_stage_pkg::*;

    localparam int DEPTH = 1 << MEM_ADDR_BITS;
    localparam int CNT_W = $clog2(RESP_DELAY + 1);

    word_t                    mem_q [DEPTH];
    logic                     busy_q;
    logic                     is_write_q;
    logic                     aw_got_q;
    logic                     w_got_q;
    logic [CNT_W-1:0]         cnt_q;
    word_t                    aw_addr_q;
    axil_w_t                  w_q;
    word_t                    rdata_q;
    logic                     aw_hs;
    logic                     w_hs;
    logic                     ar_hs;
    logic                     resp_hs;
    logic                     wr_fire;
    word_t                    wr_addr;
    axil_w_t                  wr_beat;
    logic [MEM_ADDR_BITS-1:0] wr_idx;
    logic [MEM_ADDR_BITS-1:0] rd_idx;

    // Writes win over a read offered in the same cycle
    assign aw_ready_o = !busy_q && !aw_got_q;
    assign w_ready_o  = !busy_q && !w_got_q;
    assign ar_ready_o = !busy_q && !aw_got_q && !w_got_q && !aw_valid_i && !w_valid_i;

    assign aw_hs = aw_valid_i && aw_ready_o;
    assign w_hs  = w_valid_i && w_ready_o;
    assign ar_hs = ar_valid_i && ar_ready_o;

    // aw and w may come in either order
    assign wr_addr = aw_got_q ? aw_addr_q : aw_i.addr;
    assign wr_beat = w_got_q ? w_q : w_i;
    assign wr_fire = (aw_got_q || aw_hs) && (w_got_q || w_hs);

    assign wr_idx = wr_addr[MEM_ADDR_BITS+1:2];
    assign rd_idx = ar_i.addr[MEM_ADDR_BITS+1:2];

    assign b_valid_o = busy_q && (cnt_q == '0) && is_write_q;
    assign r_valid_o = busy_q && (cnt_q == '0) && !is_write_q;
    assign resp_hs   = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i);
    assign r_o       = '{data: rdata_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q     <= 1'b0;
            is_write_q <= 1'b0;
            cnt_q      <= '0;
            aw_got_q   <= 1'b0;
            w_got_q    <= 1'b0;
        end else begin
            if (wr_fire) begin
                aw_got_q <= 1'b0;
                w_got_q  <= 1'b0;
            end else begin
                if (aw_hs) begin
                    aw_got_q <= 1'b1;
                end
                if (w_hs) begin
                    w_got_q <= 1'b1;
                end
            end
            // Response delay counter
            if (wr_fire || ar_hs) begin
                busy_q     <= 1'b1;
                is_write_q <= wr_fire;
                cnt_q      <= CNT_W'(RESP_DELAY - 1);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else if (resp_hs) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= aw_i.addr;
        end
        if (w_hs) begin
            w_q <= w_i;
        end
        if (ar_hs) begin
            rdata_q <= mem_q[rd_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_beat.strb[b]) begin
                    mem_q[wr_idx][8*b +: 8] <= wr_beat.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top #(
    parameter int MEM_ADDR_BITS = 8,
    parameter int RESP_DELAY    = 2
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          exe_valid_i,
    input  wire mem_stage_pkg::exe_req_t exe_req_i,
    output logic                         exe_ready_o,
    output logic                         wb_valid_o,
    output mem_stage_pkg::wb_req_t       wb_req_o,
    input  wire                          wb_ready_i
);
    import mem_stage_pkg::*;

    // AXI4-Lite link between control and SRAM
    logic      aw_valid;
    logic      aw_ready;
    axil_aw_t  aw;
    logic      w_valid;
    logic      w_ready;
    axil_w_t   w;
    logic      b_valid;
    logic      b_ready;
    logic      ar_valid;
    logic      ar_ready;
    axil_ar_t  ar;
    logic      r_valid;
    logic      r_ready;
    axil_r_t   r;

    // Formatter side
    mem_kind_e kind;
    logic [1:0] addr_lo;
    word_t     store_data;
    axil_w_t   w_fmt;
    word_t     load_value;

    mem_ctrl mem_ctrl_i (
        .clk, .rst,
        .exe_valid_i, .exe_req_i, .exe_ready_o,
        .wb_valid_o, .wb_req_o, .wb_ready_i,
        .aw_valid_o (aw_valid), .aw_o (aw), .aw_ready_i (aw_ready),
        .w_valid_o (w_valid), .w_o (w), .w_ready_i (w_ready),
        .b_valid_i (b_valid), .b_ready_o (b_ready),
        .ar_valid_o (ar_valid), .ar_o (ar), .ar_ready_i (ar_ready),
        .r_valid_i (r_valid), .r_i (r), .r_ready_o (r_ready),
        .kind_o (kind), .addr_lo_o (addr_lo), .store_data_o (store_data),
        .w_fmt_i (w_fmt), .load_value_i (load_value)
    );

    store_format store_format_i (
        .kind_i (kind), .addr_lo_i (addr_lo), .rs2_i (store_data), .w_o (w_fmt)
    );

    load_align load_align_i (
        .kind_i (kind), .addr_lo_i (addr_lo), .rdata_i (r.data), .value_o (load_value)
    );

    axil_sram #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS),
        .RESP_DELAY    (RESP_DELAY)
    ) axil_sram_i (
        .clk, .rst,
        .aw_valid_i (aw_valid), .aw_i (aw), .aw_ready_o (aw_ready),
        .w_valid_i (w_valid), .w_i (w), .w_ready_o (w_ready),
        .b_valid_o (b_valid), .b_ready_i (b_ready),
        .ar_valid_i (ar_valid), .ar_i (ar), .ar_ready_o (ar_ready),
        .r_valid_o (r_valid), .r_o (r), .r_ready_i (r_ready)
    );

endmodule

`default_nettype wire

//--- dv/tb_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int NUM_RECORDS = 36;
    localparam int REC_WORDS   = 7;
    localparam int MAX_CYCLES  = 40 * NUM_RECORDS + 100;

    logic     clk = 1'b0;
    logic     rst;
    logic     exe_valid;
    exe_req_t exe_req;
    logic     exe_ready;
    logic     wb_valid;
    wb_req_t  wb_req;
    logic     wb_ready = 1'b0;

    // Record columns: inst, pc, result, addr, rs2, rd, load_data
    word_t    test_mem [NUM_RECORDS * REC_WORDS];
    wb_req_t  held_req;
    logic     held            = 1'b0;
    int       accepted        = 0;
    int       out_count       = 0;
    int       mismatch_errors = 0;
    int       protocol_errors = 0;
    int       cycle_count     = 0;

    mem_stage_top #(
        .MEM_ADDR_BITS (8),
        .RESP_DELAY    (2)
    ) mem_stage_top_i (
        .clk         (clk),
        .rst         (rst),
        .exe_valid_i (exe_valid),
        .exe_req_i   (exe_req),
        .exe_ready_o (exe_ready),
        .wb_valid_o  (wb_valid),
        .wb_req_o    (wb_req),
        .wb_ready_i  (wb_ready)
    );

    always #10 clk = ~clk;

    function automatic exe_req_t record_request(input int idx);
        exe_req_t req;
        int       base;
        base       = idx * REC_WORDS;
        req.inst   = test_mem[base];
        req.pc     = test_mem[base + 1];
        req.result = test_mem[base + 2];
        req.addr   = test_mem[base + 3];
        req.rs2    = test_mem[base + 4];
        req.rd     = test_mem[base + 5][4:0];
        return req;
    endfunction

    task automatic check_field(input string name, input int idx, input word_t expected,
                               input word_t actual);
        assert (actual === expected) else begin
            mismatch_errors++;
            $display("MISMATCH wb_req.%s record %0d: expected %08h, actual %08h",
                     name, idx, expected, actual);
        end
    endtask

    task automatic check_writeback(input int idx);
        int base;
        base = idx * REC_WORDS;
        check_field("inst", idx, test_mem[base], wb_req.inst);
        check_field("pc", idx, test_mem[base + 1], wb_req.pc);
        check_field("result", idx, test_mem[base + 2], wb_req.result);
        check_field("rd", idx, test_mem[base + 5], word_t'(wb_req.rd));
        check_field("load_data", idx, test_mem[base + 6], wb_req.load_data);
    endtask

    // Write-back back-pressure, high about 70 % of cycles
    always @(negedge clk) begin
        if (rst) begin
            wb_ready = 1'b0;
        end else begin
            wb_ready = ($urandom % 100) < 70;
        end
    end

    // Monitor on the rising edge, where both handshakes resolve
    always @(posedge clk) begin
        if (!rst) begin
            if (accepted == 0) begin
                assert (!wb_valid && exe_ready) else begin
                    protocol_errors++;
                    $display("Stage not idle before the first request: wb_valid=%0b exe_ready=%0b",
                             wb_valid, exe_ready);
                end
            end
            if (exe_valid && exe_ready) begin
                // Only one instruction may be in the stage at a time
                assert (accepted == out_count) else begin
                    protocol_errors++;
                    $display("Request accepted while an earlier one was still held");
                end
                accepted++;
            end
            if (wb_valid) begin
                assert (!exe_ready) else begin
                    protocol_errors++;
                    $display("exe_ready is high while a result waits for write-back");
                end
                if (held) begin
                    assert (wb_req === held_req) else begin
                        mismatch_errors++;
                        $display("MISMATCH wb_req while stalled: expected %h, actual %h",
                                 held_req, wb_req);
                    end
                end
                if (wb_ready) begin
                    assert (out_count < NUM_RECORDS) else begin
                        protocol_errors++;
                        $display("Write-back handshake after all records were written back");
                    end
                    if (out_count < NUM_RECORDS) begin
                        check_writeback(out_count);
                    end
                    out_count++;
                    held = 1'b0;
                end else begin
                    held     = 1'b1;
                    held_req = wb_req;
                end
            end else begin
                assert (!held) else begin
                    protocol_errors++;
                    $display("wb_valid dropped before the write-back handshake");
                end
                held = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: %0d of %0d results written back after %0d cycles",
                     out_count, NUM_RECORDS, cycle_count);
            $display("Errors: %0d mismatches, %0d protocol errors, 1 timeout",
                     mismatch_errors, protocol_errors);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int unsigned gap;
        void'($urandom(32'h5823_0a45));
        rst        = 1'b1;
        exe_valid  = 1'b0;
        exe_req    = '0;
        $readmemh("dv/mem_stage_testdata.hex", test_mem);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_RECORDS; i++) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            exe_valid = 1'b1;
            exe_req   = record_request(i);
            @(posedge clk);
            while (!exe_ready) @(posedge clk);
            @(negedge clk);
            exe_valid = 1'b0;
            // Junk on the bus checks that the stage latched its copy
            exe_req   = '1;
        end
        wait (out_count == NUM_RECORDS);
        // Stray write-backs would show up here
        repeat (20) @(posedge clk);
        $display("Errors: %0d mismatches, %0d protocol errors", mismatch_errors, protocol_errors);
        if (mismatch_errors == 0 && protocol_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/mem_stage_testdata.hex
// Columns: inst pc result addr rs2 rd load_data (load_data is the expected write-back value)
// Loads use rs1=x1, stores use rs1=x1 and rs2=x2; memory starts all zero
00508193 00001000 00000105 00000000 00000000 00000003 00000000
00208233 00001004 00000300 00000000 00000200 00000004 00000000
12345337 00001008 12345000 00000000 00000000 00000006 00000000
0000B283 0000100C 00000040 00000040 00000000 00000005 00000000
0000A283 00001010 00000080 00000080 00000000 00000005 00000000
0020A023 00001014 00000100 00000100 DEADBEEF 00000000 00000000
0000A283 00001018 00000100 00000100 00000000 00000005 DEADBEEF
// Byte and halfword merges into words at 0x200 and 0x204
0020A023 0000101C 00000200 00000200 11223344 00000000 00000000
00208023 00001020 00000201 00000201 000000AA 00000000 00000000
0000A283 00001024 00000200 00000200 00000000 00000005 1122AA44
00209023 00001028 00000202 00000202 0000BEEF 00000000 00000000
00208023 0000102C 00000200 00000200 12345677 00000000 00000000
0000A283 00001030 00000200 00000200 00000000 00000005 BEEFAA77
00209023 00001034 00000204 00000204 ABCD8765 00000000 00000000
00208023 00001038 00000207 00000207 000000F0 00000000 00000000
0000A283 0000103C 00000204 00000204 00000000 00000005 F0008765
0020B023 00001040 00000204 00000204 FFFFFFFF 00000000 00000000
0000A283 00001044 00000204 00000204 00000000 00000005 F0008765
// Sub-word loads with sign bits set
0020A023 00001048 00000300 00000300 8F7EF180 00000000 00000000
00008383 0000104C 00000300 00000300 00000000 00000007 FFFFFF80
00008383 00001050 00000301 00000301 00000000 00000007 FFFFFFF1
00008383 00001054 00000302 00000302 00000000 00000007 0000007E
00008383 00001058 00000303 00000303 00000000 00000007 FFFFFF8F
0000C403 0000105C 00000300 00000300 00000000 00000008 00000080
0000C403 00001060 00000301 00000301 00000000 00000008 000000F1
0000C403 00001064 00000302 00000302 00000000 00000008 0000007E
0000C403 00001068 00000303 00000303 00000000 00000008 0000008F
00009483 0000106C 00000300 00000300 00000000 00000009 FFFFF180
00009483 00001070 00000302 00000302 00000000 00000009 FFFF8F7E
0000D503 00001074 00000300 00000300 00000000 0000000A 0000F180
0000D503 00001078 00000302 00000302 00000000 0000000A 00008F7E
0020A023 0000107C 00000304 00000304 7FFF0123 00000000 00000000
00009483 00001080 00000306 00000306 00000000 00000009 00007FFF
0000D503 00001084 00000304 00000304 00000000 0000000A 00000123
00008383 00001088 00000305 00000305 00000000 00000007 00000001
0000A283 0000108C 00000300 00000300 00000000 00000005 8F7EF180

//--- sources.f
common/mem_stage_pkg.sv
mem_stage/mem_ctrl.sv
mem_stage/load_align.sv
mem_stage/store_format.sv
hw/axil_sram.sv
hw/mem_stage_top.sv
dv/tb_mem_stage.sv

//--- Makefile
# Verilator simulation of the memory stage

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Pass or fail is taken from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
